/* verilog/alu_pkg.sv */
// Shared coprocessor types and sizes; offsets assume 8-bit AXI byte addresses and full-word writes.
package alu_pkg;

    localparam int LANE_COUNT  = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);   // Occupancy and credit width.

    // Bit 0 negates B, bits 2:1 pick the shift, bits 5:3 the logical or compare path.
    typedef enum logic [5:0] {
        OP_ADD  = 6'h00,
        OP_SUB  = 6'h01,
        OP_SHL  = 6'h02,
        OP_LSR  = 6'h04,
        OP_ASR  = 6'h06,
        OP_OR   = 6'h08,
        OP_AND  = 6'h10,
        OP_NOR  = 6'h18,
        OP_XOR  = 6'h20,
        OP_SLTU = 6'h28,
        OP_SLT  = 6'h31
    } alu_op_e;

    typedef struct packed {
        logic [31:0] opr_a;
        logic [31:0] opr_b;
        alu_op_e     op;
    } alu_cmd_t;

    typedef struct packed {
        logic [31:0] res;
        logic        z;
        logic        n;
    } alu_res_t;

    // Register map.
    localparam logic [7:0] REG_OPR_A  = 8'h00;
    localparam logic [7:0] REG_OPR_B  = 8'h04;
    localparam logic [7:0] REG_OP     = 8'h08;     // Write issues a command.
    localparam logic [7:0] REG_STATUS = 8'h0C;
    localparam logic [7:0] REG_FLAGS  = 8'h10;
    localparam logic [7:0] REG_RESULT = 8'h14;     // Read pops the head.

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

endpackage

/* verilog/alu.sv */
// Combinational 32-bit ALU; no overflow detection, and SLT uses the raw sign of A-B.
`timescale 1ns/1ps

module alu (
    input  logic [31:0]      opr_a_i,
    input  logic [31:0]      opr_b_i,
    input  alu_pkg::alu_op_e op_i,
    output logic [31:0]      res_o,
    output logic             z_o,
    output logic             n_o
);

    logic        cin;
    logic [31:0] opr_b_neg;
    logic [31:0] sum;
    logic [31:0] shift_out;
    logic [31:0] logic_out;
    logic        ltu;

    assign cin       = op_i[0];
    assign opr_b_neg = cin ? ~opr_b_i : opr_b_i;
    assign sum       = opr_a_i + opr_b_neg + {31'd0, cin};   // Two's complement subtract on SUB/SLT.
    assign ltu       = opr_a_i < opr_b_i;

    always_comb begin
        case (op_i[2:1])
            2'b01:   shift_out = opr_a_i << opr_b_i[4:0];
            2'b10:   shift_out = opr_a_i >> opr_b_i[4:0];
            2'b11:   shift_out = $unsigned($signed(opr_a_i) >>> opr_b_i[4:0]);
            default: shift_out = opr_a_i;
        endcase
    end

    always_comb begin
        case (op_i[5:3])
            3'b001:  logic_out = opr_a_i | opr_b_i;
            3'b010:  logic_out = opr_a_i & opr_b_i;
            3'b011:  logic_out = ~(opr_a_i | opr_b_i);
            3'b100:  logic_out = opr_a_i ^ opr_b_i;
            default: logic_out = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            alu_pkg::OP_ADD, alu_pkg::OP_SUB:
                res_o = sum;
            alu_pkg::OP_SHL, alu_pkg::OP_LSR, alu_pkg::OP_ASR:
                res_o = shift_out;
            alu_pkg::OP_OR, alu_pkg::OP_AND, alu_pkg::OP_NOR, alu_pkg::OP_XOR:
                res_o = logic_out;
            alu_pkg::OP_SLTU:
                res_o = {31'd0, ltu};
            alu_pkg::OP_SLT:
                res_o = {31'd0, sum[31]};
            default:
                res_o = '0;
        endcase
    end

    assign z_o = (res_o == 32'd0);
    assign n_o = sum[31];    // Adder sign, whatever the opcode.

endmodule

/* verilog/alu_lane.sv */
// One registered ALU lane; holds a single command in flight and never stalls.
`timescale 1ns/1ps

module alu_lane (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              cmd_valid_i,
    input  alu_pkg::alu_cmd_t cmd_i,
    output logic              res_valid_o,
    output alu_pkg::alu_res_t res_o
);

    logic [31:0] alu_res;
    logic        alu_z;
    logic        alu_n;

    alu u_alu (
        .opr_a_i (cmd_i.opr_a),
        .opr_b_i (cmd_i.opr_b),
        .op_i    (cmd_i.op),
        .res_o   (alu_res),
        .z_o     (alu_z),
        .n_o     (alu_n)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= cmd_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            res_o <= '{res: alu_res, z: alu_z, n: alu_n};
        end
    end

endmodule

/* verilog/alu_dispatch.sv */
// Round-robin issue to the lanes; one command per cycle, gated by result queue credits.
`timescale 1ns/1ps

module alu_dispatch (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic                                         cmd_valid_i,
    output logic                                         cmd_ready_o,
    input  alu_pkg::alu_cmd_t                            cmd_i,
    input  logic                                         pop_i,
    output logic [alu_pkg::LANE_COUNT-1:0]               lane_valid_o,
    output alu_pkg::alu_cmd_t [alu_pkg::LANE_COUNT-1:0]  lane_cmd_o
);

    localparam int PTR_W = $clog2(alu_pkg::LANE_COUNT);

    logic [PTR_W-1:0]          ptr;
    logic [alu_pkg::CNT_W-1:0] credits;
    logic                      issue;

    assign cmd_ready_o = (credits != '0);
    assign issue       = cmd_valid_i & cmd_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr          <= '0;
            credits      <= alu_pkg::CNT_W'(alu_pkg::QUEUE_DEPTH);
            lane_valid_o <= '0;
        end else begin
            lane_valid_o <= '0;
            if (issue) begin
                lane_valid_o[ptr] <= 1'b1;
                ptr               <= ptr + 1'b1;    // Wraps, lane count is a power of two.
            end
            // A credit covers a slot in a lane or the queue until the host pops it.
            case ({issue, pop_i})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue) begin
            lane_cmd_o[ptr] <= cmd_i;
        end
    end

endmodule

/* verilog/alu_collect.sv */
// In-order result queue; expects at most one valid lane per cycle and no push while full.
`timescale 1ns/1ps

module alu_collect (
    input  logic                                         clk_i,
    input  logic                                         rst_i,
    input  logic [alu_pkg::LANE_COUNT-1:0]               lane_valid_i,
    input  alu_pkg::alu_res_t [alu_pkg::LANE_COUNT-1:0]  lane_res_i,
    input  logic                                         pop_i,
    output logic                                         head_valid_o,
    output alu_pkg::alu_res_t                            head_o,
    output logic [alu_pkg::CNT_W-1:0]                    count_o
);

    localparam int PTR_W = $clog2(alu_pkg::QUEUE_DEPTH);

    alu_pkg::alu_res_t mem [alu_pkg::QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              push;
    logic              pop_ok;
    alu_pkg::alu_res_t push_res;

    // Pick whichever lane finished this cycle.
    always_comb begin
        push     = 1'b0;
        push_res = lane_res_i[0];
        for (int i = 0; i < alu_pkg::LANE_COUNT; i++) begin
            if (lane_valid_i[i]) begin
                push     = 1'b1;
                push_res = lane_res_i[i];
            end
        end
    end

    assign head_valid_o = (count_o != '0);
    assign head_o       = mem[rd_ptr];
    assign pop_ok       = pop_i & head_valid_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop_ok})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= push_res;
        end
    end

endmodule

/* verilog/alu_axil_slave.sv */
// AXI4-Lite register front end; strobes and prot are not supported, one write and one read in flight.
`timescale 1ns/1ps

module alu_axil_slave (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      awvalid_i,
    output logic                      awready_o,
    input  logic [7:0]                awaddr_i,
    input  logic                      wvalid_i,
    output logic                      wready_o,
    input  logic [31:0]               wdata_i,
    output logic                      bvalid_o,
    input  logic                      bready_i,
    output alu_pkg::axil_resp_e       bresp_o,
    input  logic                      arvalid_i,
    output logic                      arready_o,
    input  logic [7:0]                araddr_i,
    output logic                      rvalid_o,
    input  logic                      rready_i,
    output logic [31:0]               rdata_o,
    output alu_pkg::axil_resp_e       rresp_o,
    output logic                      cmd_valid_o,
    input  logic                      cmd_ready_i,
    output alu_pkg::alu_cmd_t         cmd_o,
    input  logic                      head_valid_i,
    input  alu_pkg::alu_res_t         head_i,
    input  logic [alu_pkg::CNT_W-1:0] count_i,
    output logic                      pop_o
);

    logic                aw_full;
    logic                w_full;
    logic [7:0]          aw_addr;
    logic [31:0]         w_data;
    logic [7:0]          wr_addr;
    logic [31:0]         wr_data;
    logic                wr_req;
    logic                wr_done;
    logic                wr_ok;
    logic                op_ok;
    logic                issue_op;
    logic [31:0]         opr_a;
    logic [31:0]         opr_b;
    logic                ar_hs;
    logic [31:0]         rd_data;
    alu_pkg::axil_resp_e rd_resp;
    logic                rd_pop;

    assign awready_o = ~aw_full;
    assign wready_o  = ~w_full;

    // Channels arriving this cycle are used directly, later they come from the holding regs.
    assign wr_addr  = aw_full ? aw_addr : awaddr_i;
    assign wr_data  = w_full ? w_data : wdata_i;
    assign wr_req   = (aw_full | awvalid_i) & (w_full | wvalid_i) & ~bvalid_o;

    always_comb begin
        case (wr_data[5:0])
            alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_SHL, alu_pkg::OP_LSR,
            alu_pkg::OP_ASR, alu_pkg::OP_OR, alu_pkg::OP_AND, alu_pkg::OP_NOR,
            alu_pkg::OP_XOR, alu_pkg::OP_SLTU, alu_pkg::OP_SLT:
                op_ok = (wr_data[31:6] == '0);
            default:
                op_ok = 1'b0;
        endcase
    end

    always_comb begin
        case (wr_addr)
            alu_pkg::REG_OPR_A, alu_pkg::REG_OPR_B: wr_ok = 1'b1;
            alu_pkg::REG_OP:                        wr_ok = op_ok;
            default:                                wr_ok = 1'b0;
        endcase
    end

    assign issue_op    = (wr_addr == alu_pkg::REG_OP) & op_ok;
    assign cmd_valid_o = wr_req & issue_op;
    assign wr_done     = wr_req & (~issue_op | cmd_ready_i);   // OP write waits for a credit.
    assign cmd_o       = '{opr_a: opr_a, opr_b: opr_b, op: alu_pkg::alu_op_e'(wr_data[5:0])};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            aw_full  <= 1'b0;
            w_full   <= 1'b0;
            bvalid_o <= 1'b0;
            bresp_o  <= alu_pkg::RESP_OKAY;
        end else begin
            aw_full <= (aw_full | awvalid_i) & ~wr_done;
            w_full  <= (w_full | wvalid_i) & ~wr_done;
            if (wr_done) begin
                bvalid_o <= 1'b1;
                bresp_o  <= wr_ok ? alu_pkg::RESP_OKAY : alu_pkg::RESP_SLVERR;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (awvalid_i & awready_o) begin
            aw_addr <= awaddr_i;
        end
        if (wvalid_i & wready_o) begin
            w_data <= wdata_i;
        end
        if (wr_done && wr_addr == alu_pkg::REG_OPR_A) begin
            opr_a <= wr_data;
        end
        if (wr_done && wr_addr == alu_pkg::REG_OPR_B) begin
            opr_b <= wr_data;
        end
    end

    assign arready_o = ~rvalid_o;
    assign ar_hs     = arvalid_i & arready_o;

    always_comb begin
        rd_data = '0;
        rd_resp = alu_pkg::RESP_OKAY;
        rd_pop  = 1'b0;
        case (araddr_i)
            alu_pkg::REG_STATUS: begin
                rd_data = 32'({count_i, head_valid_i});
            end
            alu_pkg::REG_FLAGS: begin
                if (head_valid_i) begin
                    rd_data = {30'd0, head_i.n, head_i.z};
                end else begin
                    rd_resp = alu_pkg::RESP_SLVERR;
                end
            end
            alu_pkg::REG_RESULT: begin
                if (head_valid_i) begin
                    rd_data = head_i.res;
                    rd_pop  = 1'b1;
                end else begin
                    rd_resp = alu_pkg::RESP_SLVERR;
                end
            end
            default: rd_resp = alu_pkg::RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rvalid_o <= 1'b0;
            pop_o    <= 1'b0;
        end else begin
            pop_o <= ar_hs & rd_pop;   // Head moves while RVALID is up, data already captured.
            if (ar_hs) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            rdata_o <= rd_data;
            rresp_o <= rd_resp;
        end
    end

endmodule

/* verilog/alu_array_top.sv */
// ALU coprocessor top; a result is readable three cycles after its OP write is accepted.
`timescale 1ns/1ps

module alu_array_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                awvalid_i,
    output logic                awready_o,
    input  logic [7:0]          awaddr_i,
    input  logic                wvalid_i,
    output logic                wready_o,
    input  logic [31:0]         wdata_i,
    output logic                bvalid_o,
    input  logic                bready_i,
    output alu_pkg::axil_resp_e bresp_o,
    input  logic                arvalid_i,
    output logic                arready_o,
    input  logic [7:0]          araddr_i,
    output logic                rvalid_o,
    input  logic                rready_i,
    output logic [31:0]         rdata_o,
    output alu_pkg::axil_resp_e rresp_o
);

    logic                                         cmd_valid;
    logic                                         cmd_ready;
    alu_pkg::alu_cmd_t                            cmd;
    logic [alu_pkg::LANE_COUNT-1:0]               lane_valid;
    alu_pkg::alu_cmd_t [alu_pkg::LANE_COUNT-1:0]  lane_cmd;
    logic [alu_pkg::LANE_COUNT-1:0]               lane_res_valid;
    alu_pkg::alu_res_t [alu_pkg::LANE_COUNT-1:0]  lane_res;
    logic                                         head_valid;
    alu_pkg::alu_res_t                            head;
    logic [alu_pkg::CNT_W-1:0]                    count;
    logic                                         pop;

    alu_axil_slave u_slave (
        .clk_i, .rst_i,
        .awvalid_i, .awready_o, .awaddr_i,
        .wvalid_i, .wready_o, .wdata_i,
        .bvalid_o, .bready_i, .bresp_o,
        .arvalid_i, .arready_o, .araddr_i,
        .rvalid_o, .rready_i, .rdata_o, .rresp_o,
        .cmd_valid_o  (cmd_valid),
        .cmd_ready_i  (cmd_ready),
        .cmd_o        (cmd),
        .head_valid_i (head_valid),
        .head_i       (head),
        .count_i      (count),
        .pop_o        (pop)
    );

    alu_dispatch u_dispatch (
        .clk_i, .rst_i,
        .cmd_valid_i  (cmd_valid),
        .cmd_ready_o  (cmd_ready),
        .cmd_i        (cmd),
        .pop_i        (pop),
        .lane_valid_o (lane_valid),
        .lane_cmd_o   (lane_cmd)
    );

    for (genvar i = 0; i < alu_pkg::LANE_COUNT; i++) begin : g_lane
        alu_lane u_lane (
            .clk_i, .rst_i,
            .cmd_valid_i (lane_valid[i]),
            .cmd_i       (lane_cmd[i]),
            .res_valid_o (lane_res_valid[i]),
            .res_o       (lane_res[i])
        );
    end

    alu_collect u_collect (
        .clk_i, .rst_i,
        .lane_valid_i (lane_res_valid),
        .lane_res_i   (lane_res),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head),
        .count_o      (count)
    );

endmodule

/* sim/alu_array_assert.sv */
// Bound into alu_array_top; queue checks read alu_collect internals by hierarchical name.
`timescale 1ns/1ps

module alu_array_assert (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      awvalid_i,
    input logic                      awready_i,
    input logic                      wvalid_i,
    input logic                      wready_i,
    input logic                      bvalid_i,
    input logic                      bready_i,
    input logic                      arvalid_i,
    input logic                      arready_i,
    input logic                      rvalid_i,
    input logic                      rready_i,
    input logic [31:0]               rdata_i,
    input logic [alu_pkg::CNT_W-1:0] count_i,
    input logic                      push_i
);

    a_aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        awvalid_i && !awready_i |=> awvalid_i) else $error("AWVALID dropped before AWREADY");
    a_w_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        wvalid_i && !wready_i |=> wvalid_i) else $error("WVALID dropped before WREADY");
    a_ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        arvalid_i && !arready_i |=> arvalid_i) else $error("ARVALID dropped before ARREADY");
    a_b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        bvalid_i && !bready_i |=> bvalid_i) else $error("BVALID dropped before BREADY");
    a_r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
        else $error("RVALID or RDATA changed while stalled");

    a_count_max: assert property (@(posedge clk_i) disable iff (rst_i)
        count_i <= alu_pkg::QUEUE_DEPTH) else $error("Queue count above depth");
    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> count_i < alu_pkg::QUEUE_DEPTH) else $error("Push into a full queue");

endmodule

bind alu_array_top alu_array_assert u_assert (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .awvalid_i (awvalid_i),
    .awready_i (awready_o),
    .wvalid_i  (wvalid_i),
    .wready_i  (wready_o),
    .bvalid_i  (bvalid_o),
    .bready_i  (bready_i),
    .arvalid_i (arvalid_i),
    .arready_i (arready_o),
    .rvalid_i  (rvalid_o),
    .rready_i  (rready_i),
    .rdata_i   (rdata_o),
    .count_i   (u_collect.count_o),
    .push_i    (u_collect.push)
);

/* sim/alu_array_checker.sv */
// Passive AXI4-Lite monitor; assumes at most one write and one read in flight.
`timescale 1ns/1ps

module alu_array_checker (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                awvalid_i,
    input  logic                awready_i,
    input  logic [7:0]          awaddr_i,
    input  logic                wvalid_i,
    input  logic                wready_i,
    input  logic [31:0]         wdata_i,
    input  logic                bvalid_i,
    input  logic                bready_i,
    input  alu_pkg::axil_resp_e bresp_i,
    input  logic                arvalid_i,
    input  logic                arready_i,
    input  logic [7:0]          araddr_i,
    input  logic                rvalid_i,
    input  logic                rready_i,
    input  logic [31:0]         rdata_i,
    input  alu_pkg::axil_resp_e rresp_i,
    output int                  errors_o
);

    logic [33:0]         q_val [$];   // {res, z, n} per entry.
    int                  q_rdy [$];   // First cycle the entry shows in the DUT queue.
    int                  cycle;
    logic [7:0]          pend_addr;
    logic [31:0]         pend_data;
    logic [31:0]         opr_a;
    logic [31:0]         opr_b;
    logic [31:0]         exp_data;
    alu_pkg::axil_resp_e exp_resp;

    // Expected {res, z, n} worked out from the opcode rules.
    function automatic logic [33:0] expect_entry(logic [31:0] a, logic [31:0] b, logic [5:0] op);
        logic [31:0] sum;
        logic [31:0] diff;
        logic [31:0] r;
        sum  = a + b;
        diff = a - b;
        case (op)
            alu_pkg::OP_ADD:  r = sum;
            alu_pkg::OP_SUB:  r = diff;
            alu_pkg::OP_SHL:  r = a << b[4:0];
            alu_pkg::OP_LSR:  r = a >> b[4:0];
            alu_pkg::OP_ASR:  r = $unsigned($signed(a) >>> b[4:0]);
            alu_pkg::OP_OR:   r = a | b;
            alu_pkg::OP_AND:  r = a & b;
            alu_pkg::OP_NOR:  r = ~(a | b);
            alu_pkg::OP_XOR:  r = a ^ b;
            alu_pkg::OP_SLTU: r = {31'd0, a < b};
            alu_pkg::OP_SLT:  r = {31'd0, diff[31]};
            default:          r = '0;
        endcase
        return {r, r == 32'd0, op[0] ? diff[31] : sum[31]};
    endfunction

    function automatic bit legal_op(logic [31:0] d);
        if (d[31:6] != '0) return 0;
        case (d[5:0])
            6'h00, 6'h01, 6'h02, 6'h04, 6'h06, 6'h08,
            6'h10, 6'h18, 6'h20, 6'h28, 6'h31: return 1;
            default: return 0;
        endcase
    endfunction

    function automatic int visible_count();
        int n;
        n = 0;
        foreach (q_rdy[i]) if (q_rdy[i] <= cycle) n++;
        return n;
    endfunction

    task automatic check_write();
        bit ok;
        ok = (pend_addr == alu_pkg::REG_OPR_A) || (pend_addr == alu_pkg::REG_OPR_B) ||
             (pend_addr == alu_pkg::REG_OP && legal_op(pend_data));
        if (bresp_i != (ok ? alu_pkg::RESP_OKAY : alu_pkg::RESP_SLVERR)) begin
            $display("FAIL t=%0t bresp: expected %0d got %0d (addr %h)", $time,
                     ok ? alu_pkg::RESP_OKAY : alu_pkg::RESP_SLVERR, bresp_i, pend_addr);
            errors_o++;
        end
        if (ok) begin
            if (pend_addr == alu_pkg::REG_OPR_A) opr_a = pend_data;
            if (pend_addr == alu_pkg::REG_OPR_B) opr_b = pend_data;
            if (pend_addr == alu_pkg::REG_OP) begin
                q_val.push_back(expect_entry(opr_a, opr_b, pend_data[5:0]));
                q_rdy.push_back(cycle + 2);
            end
        end
    endtask

    task automatic predict_read();
        int vis;
        vis      = visible_count();
        exp_data = '0;
        exp_resp = alu_pkg::RESP_OKAY;
        case (araddr_i)
            alu_pkg::REG_STATUS: exp_data = 32'(vis * 2 + (vis != 0 ? 1 : 0));
            alu_pkg::REG_FLAGS: begin
                if (vis != 0) exp_data = {30'd0, q_val[0][0], q_val[0][1]};
                else exp_resp = alu_pkg::RESP_SLVERR;
            end
            alu_pkg::REG_RESULT: begin
                if (vis != 0) begin
                    exp_data = q_val[0][33:2];
                    void'(q_val.pop_front());
                    void'(q_rdy.pop_front());
                end else begin
                    exp_resp = alu_pkg::RESP_SLVERR;
                end
            end
            default: exp_resp = alu_pkg::RESP_SLVERR;
        endcase
    endtask

    always @(posedge clk_i) begin
        if (rst_i) begin
            errors_o = 0;
            cycle    = 0;
            q_val.delete();
            q_rdy.delete();
        end else begin
            cycle++;
            if (awvalid_i && awready_i) pend_addr = awaddr_i;
            if (wvalid_i && wready_i) pend_data = wdata_i;
            if (bvalid_i && bready_i) check_write();
            if (rvalid_i && rready_i) begin
                if (rdata_i !== exp_data) begin
                    $display("FAIL t=%0t rdata: expected %h got %h", $time, exp_data, rdata_i);
                    errors_o++;
                end
                if (rresp_i !== exp_resp) begin
                    $display("FAIL t=%0t rresp: expected %0d got %0d", $time, exp_resp, rresp_i);
                    errors_o++;
                end
            end
            if (arvalid_i && arready_i) predict_read();
        end
    end

endmodule

/* sim/alu_array_tb.sv */
// Drives on the falling edge, samples on the rising edge; BREADY stays high except as noted.
`timescale 1ns/1ps

module alu_array_tb;

    localparam int     NUM_RANDOM = 200;
    localparam int     NUM_CMDS   = 8 * 11 + NUM_RANDOM + 8;
    localparam longint TIMEOUT_NS = (NUM_CMDS * 40 + 1000) * 20;

    logic                clk, rst;
    logic                awvalid, awready, wvalid, wready, bvalid, bready;
    logic                arvalid, arready, rvalid, rready;
    logic [7:0]          awaddr, araddr;
    logic [31:0]         wdata, rdata;
    alu_pkg::axil_resp_e bresp, rresp;
    int                  tb_errors;
    int                  chk_errors;
    logic [31:0]         edge_a [8] = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF,
                                        32'h8000_0001, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000};
    logic [31:0]         edge_b [8] = '{32'h0, 32'hFFFF_FFFF, 32'h1, 32'h0,
                                        32'd31, 32'h0, 32'h1, 32'h7FFF_FFFF};

    alu_array_top UUT (
        .clk_i (clk), .rst_i (rst),
        .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
        .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata),
        .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp),
        .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
        .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rresp_o (rresp)
    );

    alu_array_checker u_checker (
        .clk_i (clk), .rst_i (rst),
        .awvalid_i (awvalid), .awready_i (awready), .awaddr_i (awaddr),
        .wvalid_i (wvalid), .wready_i (wready), .wdata_i (wdata),
        .bvalid_i (bvalid), .bready_i (bready), .bresp_i (bresp),
        .arvalid_i (arvalid), .arready_i (arready), .araddr_i (araddr),
        .rvalid_i (rvalid), .rready_i (rready), .rdata_i (rdata), .rresp_i (rresp),
        .errors_o (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [5:0] op_at(int i);
        logic [5:0] ops [11] = '{6'h00, 6'h01, 6'h02, 6'h04, 6'h06, 6'h08,
                                 6'h10, 6'h18, 6'h20, 6'h28, 6'h31};
        return ops[i % 11];
    endfunction

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             output alu_pkg::axil_resp_e resp);
        bit aw_done;
        bit w_done;
        aw_done = 0;
        w_done  = 0;
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (awready) aw_done = 1;
            if (wready) w_done = 1;
            @(negedge clk);
            if (aw_done) awvalid = 1'b0;
            if (w_done) wvalid = 1'b0;
        end
        do @(posedge clk); while (!bvalid);
        resp = bresp;
    endtask

    // Hold keeps RREADY low for that many cycles once RVALID is up.
    task automatic read_reg(input logic [7:0] addr, input int hold, output logic [31:0] data,
                            output alu_pkg::axil_resp_e resp);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = (hold == 0);
        do @(posedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            @(posedge clk);
            if (!rvalid || rdata !== data) begin
                $display("ERROR t=%0t read data changed while RREADY was held low", $time);
                tb_errors++;
            end
        end
        if (hold != 0) begin
            @(negedge clk);
            rready = 1'b1;
            @(posedge clk);
        end
    endtask

    task automatic issue(input logic [31:0] a, input logic [31:0] b, input logic [5:0] op);
        alu_pkg::axil_resp_e r;
        write_reg(alu_pkg::REG_OPR_A, a, r);
        write_reg(alu_pkg::REG_OPR_B, b, r);
        write_reg(alu_pkg::REG_OP, {26'd0, op}, r);
    endtask

    task automatic wait_result();
        logic [31:0]         d;
        alu_pkg::axil_resp_e r;
        d = '0;
        while (!d[0]) read_reg(alu_pkg::REG_STATUS, 0, d, r);
    endtask

    task automatic run_cmd(input logic [31:0] a, input logic [31:0] b, input logic [5:0] op);
        logic [31:0]         d;
        alu_pkg::axil_resp_e r;
        issue(a, b, op);
        wait_result();
        read_reg(alu_pkg::REG_FLAGS, 0, d, r);
        read_reg(alu_pkg::REG_RESULT, 0, d, r);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0]         d;
        alu_pkg::axil_resp_e r;
        bit                  fifth_done;
        tb_errors = 0;
        rst       = 1'b1;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        bready    = 1'b1;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b1;
        void'($urandom(91));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Error responses with the queue empty.
        write_reg(alu_pkg::REG_OP, 32'h3, r);
        if (r != alu_pkg::RESP_SLVERR) begin
            $display("ERROR t=%0t undefined opcode was not rejected", $time);
            tb_errors++;
        end
        read_reg(alu_pkg::REG_STATUS, 0, d, r);
        read_reg(alu_pkg::REG_RESULT, 0, d, r);
        read_reg(alu_pkg::REG_FLAGS, 0, d, r);
        write_reg(alu_pkg::REG_STATUS, 32'h1, r);
        write_reg(8'h3C, 32'h1, r);
        read_reg(8'h40, 0, d, r);

        foreach (edge_a[i])
            for (int k = 0; k < 11; k++) run_cmd(edge_a[i], edge_b[i], op_at(k));

        repeat (NUM_RANDOM) run_cmd($urandom, $urandom, op_at($urandom % 11));

        // Fill every credit, then the fifth and sixth OP writes wait on pops.
        for (int k = 0; k < 4; k++) issue($urandom, $urandom, op_at(k));
        read_reg(alu_pkg::REG_STATUS, 0, d, r);
        fifth_done = 1'b0;
        fork
            begin
                issue(32'd5, 32'd3, alu_pkg::OP_SUB);
                fifth_done = 1'b1;
                issue(32'd6, 32'd2, alu_pkg::OP_SHL);
            end
            begin
                repeat (20) @(posedge clk);
                if (fifth_done) begin
                    $display("ERROR t=%0t fifth OP write completed with no credit", $time);
                    tb_errors++;
                end
                read_reg(alu_pkg::REG_RESULT, 0, d, r);
                read_reg(alu_pkg::REG_STATUS, 0, d, r);
                repeat (12) @(posedge clk);
                read_reg(alu_pkg::REG_RESULT, 0, d, r);
            end
        join
        repeat (4) begin
            wait_result();
            read_reg(alu_pkg::REG_RESULT, 0, d, r);
        end

        // Stalled read pops exactly one of two entries.
        issue(32'h1234_5678, 32'h1, alu_pkg::OP_ADD);
        issue(32'hF0F0_F0F0, 32'hFF00_FF00, alu_pkg::OP_XOR);
        wait_result();
        read_reg(alu_pkg::REG_RESULT, 5, d, r);
        read_reg(alu_pkg::REG_STATUS, 0, d, r);
        wait_result();
        read_reg(alu_pkg::REG_RESULT, 0, d, r);
        read_reg(alu_pkg::REG_STATUS, 0, d, r);

        // BREADY low here, so BVALID must wait for it.
        @(negedge clk);
        bready = 1'b0;
        write_reg(alu_pkg::REG_OPR_A, 32'h0000_00A5, r);
        repeat (3) @(posedge clk);
        @(negedge clk);
        bready = 1'b1;
        @(posedge clk);

        repeat (4) @(posedge clk);
        $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
verilog/alu_pkg.sv
verilog/alu.sv
verilog/alu_lane.sv
verilog/alu_dispatch.sv
verilog/alu_collect.sv
verilog/alu_axil_slave.sv
verilog/alu_array_top.sv
sim/alu_array_assert.sv
sim/alu_array_checker.sv
sim/alu_array_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the ALU coprocessor testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module alu_array_tb -o alu_array_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/alu_array_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0
